/* project.f */
hw/ahb_pkg.sv
hw/eth_dma_pkg.sv
hw/dma_req_if.sv
hw/dma_datalink_fsm.sv
hw/descriptor_select.sv
hw/dma_word_counter.sv
hw/ahb_read_master.sv
hw/tx_word_fifo.sv
hw/eth_dma_tx_top.sv
testbench/tb_eth_dma_tx.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eth_dma_tx
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tx_cases.txt */
# ndesc addr0 len0 addr1 len1 addr2 len2 addr3 len3 err_beat stall
# addresses in hex, lengths in bytes, err_beat -1 for none, stall 0..7 (7 is slowest)
1 00001000 64 00000000 0 00000000 0 00000000 0 -1 0
2 00002000 30 00002400 8 00000000 0 00000000 0 -1 2
4 00003000 17 00003100 4 00003200 3 00003300 40 -1 3
3 00004000 12 00004100 0 00004200 20 00000000 0 -1 1
1 00005000 256 00000000 0 00000000 0 00000000 0 -1 7
1 00006000 64 00000000 0 00000000 0 00000000 0 5 2
2 00007000 36 00007400 5 00000000 0 00000000 0 -1 4
1 00008000 16 00000000 0 00000000 0 00000000 0 0 0
4 00009000 100 00009200 1 00009300 60 00009400 28 -1 6
1 0000a000 4 00000000 0 00000000 0 00000000 0 -1 5

/* testbench/tb_eth_dma_tx.sv */
// Testbench for the transmit DMA data link with AHB slave and protocol engine models
// cases come from testbench/tx_cases.txt and the build takes project.f
`default_nettype none

module tb_eth_dma_tx;
	import ahb_pkg::*;

	localparam int DEPTH = 16;
	localparam int MAX_CASES = 32;
	localparam logic [31:0] DATA_KEY = 32'h5a5a5a5a;

	logic        ahb_hclk;
	logic        ahb_hrstn;
	logic        txdb_enable;
	logic        ahbmst_logic_clr;
	logic [1:0]  r_tdes_num;
	logic [31:0] r_tdes00, r_tdes02, r_tdes10, r_tdes12;
	logic [31:0] r_tdes20, r_tdes22, r_tdes30, r_tdes32;
	logic        ahb_hready;
	logic [1:0]  ahb_hresp;
	logic [31:0] ahb_hrdata;
	logic        txdb_pe2fifo_rdreq;
	logic [1:0]  ahb_htrans;
	logic [2:0]  ahb_hsize;
	logic        ahb_hwrite;
	logic [2:0]  ahb_hburst;
	logic [31:0] ahb_haddr;
	logic [31:0] txdb_fifo2pe_rdata;
	logic        txdb_fifo2pe_empty, txdb_data_ready, txdb_process_doing, txdb_enable_end;
	logic        dl_ahbmst_error, int_status_dma_hresp_error, int_status_dma_process_finish;

	// case table
	int          case_num;
	int          c_ndesc [MAX_CASES];
	logic [31:0] c_addr [MAX_CASES][4];
	int          c_len [MAX_CASES][4];
	int          c_err [MAX_CASES];
	int          c_stall [MAX_CASES];

	int   seed;
	int   cycles;
	int   cycle_limit;
	int   cur;
	logic in_reset, want_enable, want_clr, engine_on;

	// slave model state and the last sampled bus cycle
	logic        dph_active, err_second;
	logic [31:0] dph_addr;
	int          beat_idx, err_beat, stall;
	logic        cap_valid, cap_ready, cap_err, cap_write;
	logic [1:0]  cap_trans;
	logic [2:0]  cap_burst, cap_size;
	logic [31:0] cap_addr;

	// expected words and address phases
	logic [31:0] exp_words [$];
	logic [31:0] exp_baddr [$];
	logic [1:0]  exp_btrans [$];
	logic [2:0]  exp_bburst [$];
	int popped, outstanding, fin_cnt, end_cnt, err_cnt;
	logic err_seen;

	eth_dma_tx_top #(.FIFO_DEPTH(DEPTH)) uut (
		.ahb_hclk(ahb_hclk), .ahb_hrstn(ahb_hrstn), .txdb_enable(txdb_enable),
		.ahbmst_logic_clr(ahbmst_logic_clr), .r_tdes_num(r_tdes_num),
		.r_tdes00(r_tdes00), .r_tdes02(r_tdes02), .r_tdes10(r_tdes10), .r_tdes12(r_tdes12),
		.r_tdes20(r_tdes20), .r_tdes22(r_tdes22), .r_tdes30(r_tdes30), .r_tdes32(r_tdes32),
		.ahb_hready(ahb_hready), .ahb_hresp(ahb_hresp), .ahb_hrdata(ahb_hrdata),
		.txdb_pe2fifo_rdreq(txdb_pe2fifo_rdreq), .ahb_htrans(ahb_htrans),
		.ahb_hsize(ahb_hsize), .ahb_hwrite(ahb_hwrite), .ahb_hburst(ahb_hburst),
		.ahb_haddr(ahb_haddr), .txdb_fifo2pe_rdata(txdb_fifo2pe_rdata),
		.txdb_fifo2pe_empty(txdb_fifo2pe_empty), .txdb_data_ready(txdb_data_ready),
		.txdb_process_doing(txdb_process_doing), .txdb_enable_end(txdb_enable_end),
		.dl_ahbmst_error(dl_ahbmst_error),
		.int_status_dma_hresp_error(int_status_dma_hresp_error),
		.int_status_dma_process_finish(int_status_dma_process_finish)
	);

	initial
	begin
		ahb_hclk = 1'b0;
		forever #2 ahb_hclk = ~ahb_hclk;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("FAIL t=%0t %s: got %h expected %h", $time, msg, actual, expected);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic load_cases();
		int fd;
		int n;
		int nd, l0, l1, l2, l3, e, s;
		logic [31:0] a0, a1, a2, a3;
		string line;
		fd = $fopen("testbench/tx_cases.txt", "r");
		if (fd == 0)
		begin
			$display("case file testbench/tx_cases.txt could not be opened");
			$display("TEST FAILED");
			$fatal(1);
		end
		case_num = 0;
		cycle_limit = 1000;
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			// skip column notes and blank lines
			if (n == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%d %h %d %h %d %h %d %h %d %d %d",
				nd, a0, l0, a1, l1, a2, l2, a3, l3, e, s);
			if (n != 11 || case_num >= MAX_CASES)
			begin
				$display("case file line is malformed or the table is full");
				$display("TEST FAILED");
				$fatal(1);
			end
			c_ndesc[case_num] = nd;
			c_addr[case_num][0] = a0;
			c_addr[case_num][1] = a1;
			c_addr[case_num][2] = a2;
			c_addr[case_num][3] = a3;
			c_len[case_num][0] = l0;
			c_len[case_num][1] = l1;
			c_len[case_num][2] = l2;
			c_len[case_num][3] = l3;
			c_err[case_num] = e;
			c_stall[case_num] = s;
			// 200 cycles per word over all cases
			cycle_limit += 200 * ((l0 + 3) / 4 + (l1 + 3) / 4 + (l2 + 3) / 4 + (l3 + 3) / 4);
			case_num++;
		end
		$fclose(fd);
	endtask

	// expected words by the address rule and beats as INCR4 while four remain then singles
	task automatic expect_descriptor(input logic [31:0] addr, input int len);
		int words;
		int rem;
		logic [31:0] b;
		words = (len + 3) / 4;
		for (int j = 0; j < words; j++)
			exp_words.push_back((addr + 32'(4 * j)) ^ DATA_KEY);
		rem = words;
		b = addr;
		while (rem >= 4)
		begin
			for (int j = 0; j < 4; j++)
			begin
				exp_baddr.push_back(b + 32'(4 * j));
				exp_btrans.push_back(j == 0 ? HTRANS_NONSEQ : HTRANS_SEQ);
				exp_bburst.push_back(HBURST_INCR4);
			end
			b = b + 32'd16;
			rem -= 4;
		end
		while (rem > 0)
		begin
			exp_baddr.push_back(b);
			exp_btrans.push_back(HTRANS_NONSEQ);
			exp_bburst.push_back(HBURST_SINGLE);
			b = b + 32'd4;
			rem--;
		end
	endtask

	task automatic verify_address_phase();
		check_value(32'(exp_baddr.size() != 0), 1, "address phase while none expected");
		check_value(cap_addr, exp_baddr.pop_front(), "beat haddr");
		check_value(cap_trans, exp_btrans.pop_front(), "beat htrans");
		check_value(cap_burst, exp_bburst.pop_front(), "beat hburst");
		check_value(cap_size, HSIZE_WORD, "beat hsize");
		check_value(cap_write, 0, "beat hwrite");
	endtask

	// ====================
	// one bus cycle
	// ====================

	task automatic tick();
		@(negedge ahb_hclk);
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1);
		end
		// apply what the rising edge saw in the last cycle
		if (cap_err)
		begin
			dph_active = 1'b0;
			err_second = 1'b1;
		end
		else if (cap_ready)
		begin
			if (dph_active)
			begin
				beat_idx++;
				dph_active = 1'b0;
			end
			if (cap_valid)
			begin
				verify_address_phase();
				dph_active = 1'b1;
				dph_addr = cap_addr;
				outstanding++;
			end
		end
		ahb_hrstn = !in_reset;
		txdb_enable = want_enable;
		ahbmst_logic_clr = want_clr;
		r_tdes_num = 2'(c_ndesc[cur] - 1);
		r_tdes00 = c_addr[cur][0];
		r_tdes02 = 32'(c_len[cur][0]);
		r_tdes10 = c_addr[cur][1];
		r_tdes12 = 32'(c_len[cur][1]);
		r_tdes20 = c_addr[cur][2];
		r_tdes22 = 32'(c_len[cur][2]);
		r_tdes30 = c_addr[cur][3];
		r_tdes32 = 32'(c_len[cur][3]);
		// slave response with a two-cycle error on the chosen beat
		ahb_hrdata = 32'd0;
		ahb_hresp = 2'b00;
		ahb_hready = 1'b1;
		if (err_second)
		begin
			ahb_hresp = HRESP_ERROR;
			err_second = 1'b0;
		end
		else if (dph_active)
		begin
			ahb_hrdata = dph_addr ^ DATA_KEY;
			if (beat_idx == err_beat)
			begin
				ahb_hresp = HRESP_ERROR;
				ahb_hready = 1'b0;
			end
			else
				ahb_hready = ($random(seed) & 32'h7) >= (stall / 2);
		end
		// protocol engine pauses more often at higher stall
		txdb_pe2fifo_rdreq = 1'b0;
		if (engine_on && !txdb_fifo2pe_empty && (($random(seed) & 32'h7) >= stall))
		begin
			txdb_pe2fifo_rdreq = 1'b1;
			check_value(32'(exp_words.size() != 0), 1, "word popped while none expected");
			check_value(txdb_fifo2pe_rdata, exp_words.pop_front(), "popped word");
			popped++;
			outstanding--;
		end
		#1;
		// error flag follows the error pulse by one edge and holds until clear
		if (err_seen)
			check_value(dl_ahbmst_error, 1, "error flag held until clear");
		else
			check_value(dl_ahbmst_error, 0, "error flag without an error");
		// status pulses settle by mid low phase
		if (int_status_dma_process_finish)
		begin
			fin_cnt++;
			check_value(txdb_process_doing, 1, "process doing at descriptor finish");
		end
		if (txdb_enable_end)
		begin
			end_cnt++;
			check_value(fin_cnt, c_ndesc[cur], "descriptors done at enable end");
		end
		if (int_status_dma_hresp_error)
		begin
			err_cnt++;
			err_seen = 1'b1;
		end
		check_value(txdb_data_ready, !txdb_fifo2pe_empty, "data ready against empty");
		check_value(32'(outstanding <= DEPTH), 1, "words in flight beyond FIFO depth");
		cap_valid = ahb_htrans != HTRANS_IDLE;
		cap_trans = ahb_htrans;
		cap_burst = ahb_hburst;
		cap_addr = ahb_haddr;
		cap_size = ahb_hsize;
		cap_write = ahb_hwrite;
		cap_ready = ahb_hready;
		cap_err = dph_active && (ahb_hresp == HRESP_ERROR);
	endtask

	task automatic run_case(input int i);
		int total;
		cur = i;
		exp_words.delete();
		exp_baddr.delete();
		exp_btrans.delete();
		exp_bburst.delete();
		popped = 0;
		outstanding = 0;
		fin_cnt = 0;
		end_cnt = 0;
		err_cnt = 0;
		err_seen = 1'b0;
		beat_idx = 0;
		stall = c_stall[i];
		total = 0;
		for (int d = 0; d < c_ndesc[i]; d++)
		begin
			expect_descriptor(c_addr[i][d], c_len[i][d]);
			total += (c_len[i][d] + 3) / 4;
		end
		err_beat = (c_err[i] >= 0 && c_err[i] < total) ? c_err[i] : -1;
		engine_on = 1'b1;
		want_enable = 1'b1;
		tick();
		want_enable = 1'b0;
		if (err_beat >= 0)
		begin
			// error case drains and then clears
			while (!(end_cnt >= 1 && txdb_fifo2pe_empty && !txdb_process_doing))
				tick();
			repeat (4) tick();
			check_value(err_cnt, 1, "hresp error pulses");
			check_value(fin_cnt, 1, "finish pulses in error case");
			check_value(end_cnt, 1, "enable end pulses in error case");
			check_value(popped, err_beat, "words before the error beat");
			check_value(dl_ahbmst_error, 1, "error flag before clear");
			want_clr = 1'b1;
			tick();
			want_clr = 1'b0;
			err_seen = 1'b0;
			tick();
			check_value(dl_ahbmst_error, 0, "error flag after clear");
		end
		else
		begin
			while (!(end_cnt >= 1 && popped == total && txdb_fifo2pe_empty))
				tick();
			repeat (4) tick();
			check_value(fin_cnt, c_ndesc[i], "finish pulses per descriptor");
			check_value(end_cnt, 1, "enable end pulses");
			check_value(err_cnt, 0, "hresp error pulses in clean case");
			check_value(exp_baddr.size(), 0, "address phases left over");
			check_value(popped, total, "total words received");
			check_value(ahb_htrans, HTRANS_IDLE, "bus idle after case");
			check_value(txdb_process_doing, 0, "process doing after case");
		end
		engine_on = 1'b0;
	endtask

	initial
	begin
		ahb_hrstn = 1'b0;
		txdb_enable = 1'b0;
		ahbmst_logic_clr = 1'b0;
		r_tdes_num = 2'd0;
		r_tdes00 = 32'd0;
		r_tdes02 = 32'd0;
		r_tdes10 = 32'd0;
		r_tdes12 = 32'd0;
		r_tdes20 = 32'd0;
		r_tdes22 = 32'd0;
		r_tdes30 = 32'd0;
		r_tdes32 = 32'd0;
		ahb_hready = 1'b1;
		ahb_hresp = 2'b00;
		ahb_hrdata = 32'd0;
		txdb_pe2fifo_rdreq = 1'b0;
		seed = 32'h00484f37;
		cycles = 0;
		cur = 0;
		in_reset = 1'b1;
		want_enable = 1'b0;
		want_clr = 1'b0;
		engine_on = 1'b0;
		dph_active = 1'b0;
		err_second = 1'b0;
		dph_addr = 32'd0;
		beat_idx = 0;
		err_beat = -1;
		stall = 0;
		cap_valid = 1'b0;
		cap_ready = 1'b0;
		cap_err = 1'b0;
		err_seen = 1'b0;
		outstanding = 0;
		load_cases();
		repeat (16) tick();
		in_reset = 1'b0;
		tick();
		// idle bus and quiet status out of reset
		check_value(ahb_htrans, HTRANS_IDLE, "htrans after reset");
		check_value(ahb_hwrite, 0, "hwrite after reset");
		check_value(txdb_data_ready, 0, "data ready after reset");
		check_value(txdb_process_doing, 0, "process doing after reset");
		check_value(int_status_dma_process_finish, 0, "finish pulse after reset");
		check_value(txdb_enable_end, 0, "enable end after reset");
		check_value(int_status_dma_hresp_error, 0, "error pulse after reset");
		for (int i = 0; i < case_num; i++)
			run_case(i);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/eth_dma_tx_top.sv */
// Transmit side of the Ethernet MAC DMA data link
// descriptors in, AHB reads out, words towards the protocol engine
`default_nettype none

module eth_dma_tx_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic        ahb_hclk,
	input  logic        ahb_hrstn,
	input  logic        txdb_enable,
	input  logic        ahbmst_logic_clr,
	input  logic [1:0]  r_tdes_num,
	input  logic [31:0] r_tdes00,
	input  logic [31:0] r_tdes02,
	input  logic [31:0] r_tdes10,
	input  logic [31:0] r_tdes12,
	input  logic [31:0] r_tdes20,
	input  logic [31:0] r_tdes22,
	input  logic [31:0] r_tdes30,
	input  logic [31:0] r_tdes32,
	input  logic        ahb_hready,
	input  logic [1:0]  ahb_hresp,
	input  logic [31:0] ahb_hrdata,
	input  logic        txdb_pe2fifo_rdreq,
	output logic [1:0]  ahb_htrans,
	output logic [2:0]  ahb_hsize,
	output logic        ahb_hwrite,
	output logic [2:0]  ahb_hburst,
	output logic [31:0] ahb_haddr,
	output logic [31:0] txdb_fifo2pe_rdata,
	output logic        txdb_fifo2pe_empty,
	output logic        txdb_data_ready,
	output logic        txdb_process_doing,
	output logic        txdb_enable_end,
	output logic        dl_ahbmst_error,
	output logic        int_status_dma_hresp_error,
	output logic        int_status_dma_process_finish
);

	// ==================
	// internal wiring
	// ==================

	logic                        descriptor_load;
	logic                        advance;
	logic                        process_start;
	logic                        process_finish;
	logic                        last;
	logic                        error;
	logic [31:0]                 tx_address;
	logic [11:0]                 tx_length;
	logic [$clog2(FIFO_DEPTH):0] fifo_free;

	// counter to master to fifo
	dma_req_if req_bus ();

	// tx_doing doubles as the process-doing status
	dma_datalink_fsm u_fsm (
		.ahb_hclk                      (ahb_hclk),
		.ahb_hrstn                     (ahb_hrstn),
		.txdb_enable                   (txdb_enable),
		.ahbmst_logic_clr              (ahbmst_logic_clr),
		.process_finish                (process_finish),
		.last                          (last),
		.descriptor_load               (descriptor_load),
		.advance                       (advance),
		.tx_doing                      (txdb_process_doing),
		.process_start                 (process_start),
		.txdb_enable_end               (txdb_enable_end),
		.int_status_dma_process_finish (int_status_dma_process_finish)
	);

	descriptor_select u_descriptor (
		.ahb_hclk         (ahb_hclk),
		.ahb_hrstn        (ahb_hrstn),
		.ahbmst_logic_clr (ahbmst_logic_clr),
		.descriptor_load  (descriptor_load),
		.advance          (advance),
		.r_tdes_num       (r_tdes_num),
		.r_tdes00         (r_tdes00),
		.r_tdes02         (r_tdes02),
		.r_tdes10         (r_tdes10),
		.r_tdes12         (r_tdes12),
		.r_tdes20         (r_tdes20),
		.r_tdes22         (r_tdes22),
		.r_tdes30         (r_tdes30),
		.r_tdes32         (r_tdes32),
		.tx_address       (tx_address),
		.tx_length        (tx_length),
		.last             (last)
	);

	dma_word_counter #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_counter (
		.ahb_hclk         (ahb_hclk),
		.ahb_hrstn        (ahb_hrstn),
		.ahbmst_logic_clr (ahbmst_logic_clr),
		.tx_doing         (txdb_process_doing),
		.process_start    (process_start),
		.tx_address       (tx_address),
		.tx_length        (tx_length),
		.fifo_free        (fifo_free),
		.error            (error),
		.req              (req_bus),
		.process_finish   (process_finish)
	);

	ahb_read_master u_master (
		.ahb_hclk                   (ahb_hclk),
		.ahb_hrstn                  (ahb_hrstn),
		.ahbmst_logic_clr           (ahbmst_logic_clr),
		.ahb_hready                 (ahb_hready),
		.ahb_hresp                  (ahb_hresp),
		.ahb_hrdata                 (ahb_hrdata),
		.req                        (req_bus),
		.ahb_htrans                 (ahb_htrans),
		.ahb_hsize                  (ahb_hsize),
		.ahb_hwrite                 (ahb_hwrite),
		.ahb_hburst                 (ahb_hburst),
		.ahb_haddr                  (ahb_haddr),
		.error                      (error),
		.dl_ahbmst_error            (dl_ahbmst_error),
		.int_status_dma_hresp_error (int_status_dma_hresp_error)
	);

	tx_word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.ahb_hclk           (ahb_hclk),
		.ahb_hrstn          (ahb_hrstn),
		.ahbmst_logic_clr   (ahbmst_logic_clr),
		.txdb_pe2fifo_rdreq (txdb_pe2fifo_rdreq),
		.req                (req_bus),
		.txdb_fifo2pe_rdata (txdb_fifo2pe_rdata),
		.txdb_fifo2pe_empty (txdb_fifo2pe_empty),
		.txdb_data_ready    (txdb_data_ready),
		.fifo_free          (fifo_free)
	);

endmodule

`default_nettype wire

/* hw/tx_word_fifo.sv */
// Word FIFO between the DMA read side and the transmit protocol engine
// head word is shown while not empty, rdreq pops it
`default_nettype none

module tx_word_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                        ahb_hclk,
	input  logic                        ahb_hrstn,
	input  logic                        ahbmst_logic_clr,
	input  logic                        txdb_pe2fifo_rdreq,
	dma_req_if.fifo                     req,
	output ahb_pkg::ahb_data_t          txdb_fifo2pe_rdata,
	output logic                        txdb_fifo2pe_empty,
	output logic                        txdb_data_ready,
	output logic [$clog2(FIFO_DEPTH):0] fifo_free
);
	import ahb_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int CW = AW + 1;

	ahb_data_t     mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          pop;

	assign pop = txdb_pe2fifo_rdreq && !txdb_fifo2pe_empty;
	assign txdb_fifo2pe_empty = count == '0;
	assign txdb_data_ready = !txdb_fifo2pe_empty;
	assign txdb_fifo2pe_rdata = mem[rd_ptr];
	// the counter sizes its requests from this
	assign fifo_free = CW'(FIFO_DEPTH) - count;

	always_ff @(posedge ahb_hclk)
	begin
		if (req.data_valid)
			mem[wr_ptr] <= req.data;
	end

	// pointers wrap on the power-of-two depth
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (ahbmst_logic_clr)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			wr_ptr <= wr_ptr + AW'(req.data_valid);
			rd_ptr <= rd_ptr + AW'(pop);
			count <= count + CW'(req.data_valid) - CW'(pop);
		end
	end

endmodule

`default_nettype wire

/* hw/ahb_read_master.sv */
// AHB read master for single and INCR4 transfers
// address and data phases overlap; an error response aborts the transfer
`default_nettype none

module ahb_read_master (
	input  logic               ahb_hclk,
	input  logic               ahb_hrstn,
	input  logic               ahbmst_logic_clr,
	input  logic               ahb_hready,
	input  logic [1:0]         ahb_hresp,
	input  ahb_pkg::ahb_data_t ahb_hrdata,
	dma_req_if.master          req,
	output ahb_pkg::htrans_e   ahb_htrans,
	output logic [2:0]         ahb_hsize,
	output logic               ahb_hwrite,
	output ahb_pkg::hburst_e   ahb_hburst,
	output ahb_pkg::ahb_addr_t ahb_haddr,
	output logic               error,
	output logic               dl_ahbmst_error,
	output logic               int_status_dma_hresp_error
);
	import ahb_pkg::*;
	import eth_dma_pkg::*;

	// a request has been taken and not all beats returned
	logic       active;
	// a data phase is on the bus
	logic       dph_valid;
	// address phases still to issue after the current one
	logic [1:0] addr_left;
	// data beats still to return
	logic [2:0] data_left;
	logic       addr_done;

	assign addr_done = (ahb_htrans != HTRANS_IDLE) && ahb_hready;

	// first error cycle already ends the transfer
	assign error = dph_valid && (ahb_hresp == HRESP_ERROR);
	assign int_status_dma_hresp_error = error;

	// read only, word sized
	assign ahb_hsize = HSIZE_WORD;
	assign ahb_hwrite = 1'b0;

	assign req.ack = !active && (req.single_req || req.burst_req) && !ahbmst_logic_clr;
	assign req.data = ahb_hrdata;
	assign req.data_valid = dph_valid && ahb_hready && !error;
	assign req.once_finish = req.data_valid && (data_left == 3'd1);

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			active <= 1'b0;
			dph_valid <= 1'b0;
			addr_left <= '0;
			data_left <= '0;
			ahb_htrans <= HTRANS_IDLE;
			ahb_hburst <= HBURST_SINGLE;
			ahb_haddr <= '0;
			dl_ahbmst_error <= 1'b0;
		end
		// abort, the error flag holds until the logic clear
		else if (ahbmst_logic_clr || error)
		begin
			active <= 1'b0;
			dph_valid <= 1'b0;
			addr_left <= '0;
			data_left <= '0;
			ahb_htrans <= HTRANS_IDLE;
			dl_ahbmst_error <= !ahbmst_logic_clr;
		end
		// first address phase
		else if (req.ack)
		begin
			active <= 1'b1;
			ahb_haddr <= req.addr;
			ahb_htrans <= HTRANS_NONSEQ;
			ahb_hburst <= req.burst_req ? HBURST_INCR4 : HBURST_SINGLE;
			addr_left <= req.burst_req ? 2'(BURST_WORDS - 1) : 2'd0;
			data_left <= req.burst_req ? 3'(BURST_WORDS) : 3'd1;
		end
		else
		begin
			// address accepted, its data phase starts
			if (addr_done)
			begin
				dph_valid <= 1'b1;
				if (addr_left != '0)
				begin
					ahb_haddr <= ahb_haddr + 32'd4;
					ahb_htrans <= HTRANS_SEQ;
					addr_left <= addr_left - 2'd1;
				end
				else
					ahb_htrans <= HTRANS_IDLE;
			end
			else if (req.data_valid)
				dph_valid <= 1'b0;

			if (req.data_valid)
			begin
				data_left <= data_left - 3'd1;
				if (req.once_finish)
					active <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/dma_word_counter.sv */
// Words remaining in the current descriptor; raises burst or single read
// requests when the FIFO has room and signals the end of the descriptor
`default_nettype none

module dma_word_counter #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                        ahb_hclk,
	input  logic                        ahb_hrstn,
	input  logic                        ahbmst_logic_clr,
	input  logic                        tx_doing,
	input  logic                        process_start,
	input  ahb_pkg::ahb_addr_t          tx_address,
	input  eth_dma_pkg::tx_len_t        tx_length,
	input  logic [$clog2(FIFO_DEPTH):0] fifo_free,
	input  logic                        error,
	dma_req_if.counter                  req,
	output logic                        process_finish
);
	import eth_dma_pkg::*;

	localparam int FW = $clog2(FIFO_DEPTH) + 1;

	word_cnt_t words_left;
	// a request is raised or its beats are still returning
	logic      pending;
	logic      want_burst;
	logic      want_single;

	// full burst only with four words left and four free entries
	assign want_burst = (words_left >= word_cnt_t'(BURST_WORDS))
		&& (fifo_free >= FW'(BURST_WORDS));
	// tail words go one at a time
	assign want_single = (words_left != '0) && (words_left < word_cnt_t'(BURST_WORDS))
		&& (fifo_free != '0);

	// count is stale on the load cycle
	assign process_finish = tx_doing && !process_start
		&& (((words_left == '0) && !pending) || error);

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			words_left <= '0;
			pending <= 1'b0;
			req.burst_req <= 1'b0;
			req.single_req <= 1'b0;
			req.addr <= '0;
		end
		else if (ahbmst_logic_clr)
		begin
			words_left <= '0;
			pending <= 1'b0;
			req.burst_req <= 1'b0;
			req.single_req <= 1'b0;
		end
		// the master has dropped the transfer
		else if (error)
		begin
			pending <= 1'b0;
			req.burst_req <= 1'b0;
			req.single_req <= 1'b0;
		end
		// byte length rounded up to words
		else if (process_start)
		begin
			words_left <= tx_length[11:2] + word_cnt_t'(|tx_length[1:0]);
			req.addr <= tx_address;
		end
		else if (req.ack)
		begin
			req.addr <= req.addr + (req.burst_req ? 32'(BURST_WORDS * 4) : 32'd4);
			words_left <= words_left - (req.burst_req ? word_cnt_t'(BURST_WORDS) : 10'd1);
			req.burst_req <= 1'b0;
			req.single_req <= 1'b0;
		end
		// next request waits for the last beat
		else if (req.once_finish)
			pending <= 1'b0;
		else if (tx_doing && !pending && (want_burst || want_single))
		begin
			pending <= 1'b1;
			req.burst_req <= want_burst;
			req.single_req <= !want_burst;
		end
	end

endmodule

`default_nettype wire

/* hw/descriptor_select.sv */
// Descriptor index and latched buffer address and byte length
// the FSM loads a descriptor and advances after each one
`default_nettype none

module descriptor_select (
	input  logic                 ahb_hclk,
	input  logic                 ahb_hrstn,
	input  logic                 ahbmst_logic_clr,
	input  logic                 descriptor_load,
	input  logic                 advance,
	input  eth_dma_pkg::des_idx_t r_tdes_num,
	input  ahb_pkg::ahb_data_t   r_tdes00,
	input  ahb_pkg::ahb_data_t   r_tdes02,
	input  ahb_pkg::ahb_data_t   r_tdes10,
	input  ahb_pkg::ahb_data_t   r_tdes12,
	input  ahb_pkg::ahb_data_t   r_tdes20,
	input  ahb_pkg::ahb_data_t   r_tdes22,
	input  ahb_pkg::ahb_data_t   r_tdes30,
	input  ahb_pkg::ahb_data_t   r_tdes32,
	output ahb_pkg::ahb_addr_t   tx_address,
	output eth_dma_pkg::tx_len_t tx_length,
	output logic                 last
);
	import eth_dma_pkg::*;

	des_idx_t idx;

	// r_tdes_num holds the descriptor count minus one
	assign last = idx == r_tdes_num;

	// back to the first descriptor once the request ends
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			idx <= '0;
		else if (ahbmst_logic_clr)
			idx <= '0;
		else if (advance)
			idx <= last ? '0 : idx + 2'd1;
	end

	// buffer address from tdesN0, length from the low bits of tdesN2
	always_ff @(posedge ahb_hclk)
	begin
		if (descriptor_load)
		begin
			case (idx)
			2'd0:
			begin
				tx_address <= r_tdes00;
				tx_length <= tx_len_t'(r_tdes02[11:0]);
			end
			2'd1:
			begin
				tx_address <= r_tdes10;
				tx_length <= tx_len_t'(r_tdes12[11:0]);
			end
			2'd2:
			begin
				tx_address <= r_tdes20;
				tx_length <= tx_len_t'(r_tdes22[11:0]);
			end
			default:
			begin
				tx_address <= r_tdes30;
				tx_length <= tx_len_t'(r_tdes32[11:0]);
			end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/dma_datalink_fsm.sv */
// Transmit request register and one-hot data-link FSM
// walks idle, descriptor, tx data and end once per descriptor
`default_nettype none

module dma_datalink_fsm (
	input  logic ahb_hclk,
	input  logic ahb_hrstn,
	input  logic txdb_enable,
	input  logic ahbmst_logic_clr,
	input  logic process_finish,
	input  logic last,
	output logic descriptor_load,
	output logic advance,
	output logic tx_doing,
	output logic process_start,
	output logic txdb_enable_end,
	output logic int_status_dma_process_finish
);
	import eth_dma_pkg::*;

	dl_state_e  current_state;
	dl_state_e  next_state;
	logic       tx_req;
	// registered state flags, aligned with current_state
	logic       st_descriptor;
	logic       st_tx_data;
	logic       st_end;
	logic       start_q;
	logic [1:0] end_cnt;
	logic       end_done;
	logic       finish;

	// one descriptor done
	assign finish = st_tx_data && process_finish;
	assign end_done = st_end && (end_cnt == 2'(ENDING_CYCLES - 1));

	assign descriptor_load = st_descriptor;
	assign tx_doing = st_tx_data;
	assign process_start = start_q;
	assign advance = finish;
	assign int_status_dma_process_finish = finish;
	assign txdb_enable_end = finish && last;

	// ==================
	// transmit request
	// ==================

	// set by the enable level, dropped when the last descriptor ends
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			tx_req <= 1'b0;
		else if (ahbmst_logic_clr || txdb_enable_end)
			tx_req <= 1'b0;
		else if (txdb_enable)
			tx_req <= 1'b1;
	end

	// ==================
	// state machine
	// ==================

	always_comb
	begin
		next_state = current_state;
		if (ahbmst_logic_clr)
			next_state = DL_IDLE;
		else
		begin
			case (current_state)
			DL_IDLE:
				if (tx_req)
					next_state = DL_DESCRIPTOR;
			// fields are latched during this single cycle
			DL_DESCRIPTOR:
				next_state = DL_TX_DATA;
			DL_TX_DATA:
				if (process_finish)
					next_state = DL_END;
			// request already cleared after the last descriptor
			DL_END:
				if (end_done)
					next_state = tx_req ? DL_DESCRIPTOR : DL_IDLE;
			default:
				next_state = DL_IDLE;
			endcase
		end
	end

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			current_state <= DL_IDLE;
			st_descriptor <= 1'b0;
			st_tx_data <= 1'b0;
			st_end <= 1'b0;
			start_q <= 1'b0;
		end
		else
		begin
			current_state <= next_state;
			st_descriptor <= next_state == DL_DESCRIPTOR;
			st_tx_data <= next_state == DL_TX_DATA;
			st_end <= next_state == DL_END;
			// first cycle of tx data
			start_q <= (next_state == DL_TX_DATA) && !st_tx_data;
		end
	end

	// cycles spent in END
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			end_cnt <= '0;
		else if (st_end && !end_done)
			end_cnt <= end_cnt + 2'd1;
		else
			end_cnt <= '0;
	end

endmodule

`default_nettype wire

/* hw/dma_req_if.sv */
// One transfer request from the word counter to the AHB master,
// and the words that the master returns to the FIFO
`default_nettype none

interface dma_req_if;
	import ahb_pkg::*;

	// request levels, held until ack
	logic      single_req;
	logic      burst_req;
	// word address of the first beat
	ahb_addr_t addr;
	// one-cycle pulse when the master takes the request
	logic      ack;
	// returned read data, one word per accepted data phase
	ahb_data_t data;
	logic      data_valid;
	// last beat of the accepted request
	logic      once_finish;

	modport counter (output single_req, burst_req, addr, input ack, once_finish);
	modport master (input single_req, burst_req, addr, output ack, data, data_valid, once_finish);
	modport fifo (input data, data_valid);

endinterface

`default_nettype wire

/* hw/eth_dma_pkg.sv */
// Transmit DMA data-link definitions: state encoding, descriptor field widths
// and burst sizing, shared by the FSM, the descriptor select and the word counter
`default_nettype none

package eth_dma_pkg;

	// ==================
	// data-link state
	// ==================

	// one-hot, bit positions follow the full tx/rx data link
	// arbitration and rx data are not present on this side
	typedef enum logic [5:0] {
		DL_IDLE       = 6'b000001,
		DL_DESCRIPTOR = 6'b000100,
		DL_TX_DATA    = 6'b001000,
		DL_END        = 6'b100000
	} dl_state_e;

	// ==================
	// descriptor fields
	// ==================

	// byte length, low 12 bits of tdesN2
	typedef logic [11:0] tx_len_t;
	// words still to be fetched for one descriptor
	typedef logic [9:0] word_cnt_t;
	// up to four descriptors
	typedef logic [1:0] des_idx_t;

	// words in one INCR4 burst
	localparam int BURST_WORDS = 4;
	// cycles spent in END before the next descriptor
	localparam int ENDING_CYCLES = 2;

endpackage

`default_nettype wire

/* hw/ahb_pkg.sv */
// AHB bus widths and transfer encodings
// imported by the DMA read master, the word FIFO and the request interface
`default_nettype none

package ahb_pkg;

	// address and data words
	typedef logic [31:0] ahb_addr_t;
	typedef logic [31:0] ahb_data_t;

	// transfer type, BUSY is never issued by this master
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_e;

	// only word transfers
	localparam logic [2:0] HSIZE_WORD = 3'b010;

	// burst types in use
	typedef enum logic [2:0] {
		HBURST_SINGLE = 3'b000,
		HBURST_INCR4  = 3'b011
	} hburst_e;

	// hresp code
	localparam logic [1:0] HRESP_ERROR = 2'b01;

endpackage

`default_nettype wire
